//--- hw/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// byte address width of the fetch path
`define FETCH_ADDR_W 20

// one cache tile, eight 16-bit instructions
`define FETCH_TILE_W 128

// tile memory depth, in tiles
`define FETCH_MEM_TILES 256

// cycles from accepted request to the OK pulse, at least 2
`define FETCH_MEM_LATENCY 3

`endif

//--- hw/fetchPkg.sv
`include "fetch_config.svh"

package fetchPkg;

	typedef logic [`FETCH_ADDR_W-1:0] pcAddrT;       // byte address
	typedef logic [`FETCH_ADDR_W-5:0] tileAddrT;     // byte address without low 4 bits
	typedef logic [`FETCH_TILE_W-1:0] tileDataT;     // one tile
	typedef logic [15:0] instrWordT;                 // one instruction

	// operation code toward memory, held as a level
	typedef enum logic [1:0]
	{
		MEM_OPM_READY   = 2'd0, // idle
		MEM_OPM_RD_TILE = 2'd1  // read one tile
	} memOpmT;

	// memory status back to the tile
	typedef enum logic [1:0]
	{
		MEM_OK_READY = 2'd0,
		MEM_OK_OK    = 2'd1 // one-cycle pulse with data
	} memOkT;

	// cache status toward the PC unit
	typedef enum logic [1:0]
	{
		FETCH_OK_READY = 2'd0, // not yet valid
		FETCH_OK_OK    = 2'd1, // word valid
		FETCH_OK_HOLD  = 2'd2  // stall on miss
	} fetchOkT;

	typedef enum logic [1:0]
	{
		IDLE,
		BUSY,
		RESPOND
	} tileMemStateT;

endpackage

//--- hw/fetchPcUnit.sv
`timescale 1ns/1ps

module fetchPcUnit
(
	input  logic              clock,
	input  logic              arstN,
	input  logic              fetchEnable,   // level, low holds pc
	input  logic              redirectValid, // one-cycle strobe
	input  fetchPkg::pcAddrT  redirectPc,
	input  fetchPkg::fetchOkT fetchOk,
	output fetchPkg::pcAddrT  pc
);

	import fetchPkg::*;

	pcAddrT nextPc;
	pcAddrT redirectAligned;
	logic   advance;

	// redirect targets are forced to halfword alignment
	assign redirectAligned = {redirectPc[$bits(pcAddrT)-1:1], 1'b0};

	// only step when the cache delivered a word and fetch is on
	assign advance = fetchEnable && (fetchOk == FETCH_OK_OK);

	// priority is redirect, then sequential step, then hold
	always_comb
	begin
		nextPc = pc;
		if (redirectValid)
		begin
			nextPc = redirectAligned;
		end
		else if (advance)
		begin
			nextPc = pc + pcAddrT'(2); // next halfword
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			pc <= '0;
		end
		else
		begin
			pc <= nextPc;
		end
	end

endmodule

//--- hw/icacheTile.sv
`timescale 1ns/1ps

module icacheTile
(
	input  logic                clock,
	input  logic                arstN,
	input  fetchPkg::pcAddrT    pc,
	output fetchPkg::fetchOkT   fetchOk,
	output fetchPkg::instrWordT instrWord,
	output fetchPkg::tileAddrT  memAddr,   // held stable while reading
	output fetchPkg::memOpmT    memOpm,
	input  fetchPkg::memOkT     memOk,
	input  fetchPkg::tileDataT  memData
);

	import fetchPkg::*;

	tileDataT tileData;  // the cached tile
	tileAddrT tileTag;   // tile index of tileData
	logic     tileReady; // tileData holds a filled tile

	tileAddrT pcTile;
	logic [2:0] wordIdx;
	logic     tileMiss;
	logic     fillNow;

	assign pcTile  = pc[$bits(pcAddrT)-1:4];
	assign wordIdx = pc[3:1];
	assign fillNow = (memOk == MEM_OK_OK);

	assign tileMiss = !tileReady || (tileTag != pcTile);

	// status and word follow pc in the same cycle
	always_comb
	begin
		fetchOk   = FETCH_OK_READY;
		instrWord = tileData[{wordIdx, 4'b0000} +: 16];
		if (tileMiss)
		begin
			fetchOk = FETCH_OK_HOLD;
		end
		else
		begin
			fetchOk = FETCH_OK_OK;
		end
	end

	// request side and the ready flag
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			memOpm    <= MEM_OPM_READY;
			memAddr   <= '0;
			tileReady <= 1'b0;
		end
		else if (fillNow)
		begin
			// fill lands even if pc moved away meanwhile
			memOpm    <= MEM_OPM_READY;
			tileReady <= 1'b1;
		end
		else if ((memOpm == MEM_OPM_READY) && tileMiss)
		begin
			memOpm  <= MEM_OPM_RD_TILE; // one cycle after miss seen
			memAddr <= pcTile;          // latched, stays put until OK
		end
	end

	// tile payload
	always_ff @(posedge clock)
	begin
		if (fillNow)
		begin
			tileData <= memData;
			tileTag  <= memAddr; // tag of the request, not of pc
		end
	end

endmodule

//--- hw/tileMemory.sv
`timescale 1ns/1ps

`include "fetch_config.svh"

module tileMemory
(
	input  logic               clock,
	input  logic               arstN,
	input  fetchPkg::tileAddrT memAddr,
	input  fetchPkg::memOpmT   memOpm,
	output fetchPkg::memOkT    memOk,
	output fetchPkg::tileDataT memData,
	input  logic               memWriteEn,
	input  fetchPkg::tileAddrT memWriteAddr,
	input  fetchPkg::tileDataT memWriteData
);

	import fetchPkg::*;

	localparam int Depth   = `FETCH_MEM_TILES;
	localparam int IdxW    = $clog2(Depth);
	localparam int Latency = `FETCH_MEM_LATENCY;
	localparam int CntW    = (Latency > 2) ? $clog2(Latency) : 1;

	tileDataT tiles [Depth];

	tileMemStateT state;
	logic [CntW-1:0] latCount; // remaining busy cycles
	logic [IdxW-1:0] reqIdx;    // latched request index
	logic accept;
	logic lastBusy;

	assign accept   = (state == IDLE) && (memOpm == MEM_OPM_RD_TILE);
	assign lastBusy = (state == BUSY) && (latCount == '0);

	assign memOk = (state == RESPOND) ? MEM_OK_OK : MEM_OK_READY;

	// IDLE, then Latency-1 cycles BUSY, then one RESPOND cycle
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state    <= IDLE;
			latCount <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (accept)
					begin
						state    <= BUSY;
						latCount <= CntW'(Latency - 2);
					end
				end
				BUSY:
				begin
					if (lastBusy)
						state <= RESPOND;
					else
						latCount <= latCount - 1'b1;
				end
				default:
				begin
					state <= IDLE; // back to idle for at least a cycle
				end
			endcase
		end
	end

	// storage, write port and read data
	always_ff @(posedge clock)
	begin
		if (memWriteEn)
			tiles[memWriteAddr[IdxW-1:0]] <= memWriteData;
		if (accept)
			reqIdx <= memAddr[IdxW-1:0];
		if (lastBusy)
			memData <= tiles[reqIdx]; // valid with the OK pulse
	end

endmodule

//--- hw/fetchFrontEnd.sv
`timescale 1ns/1ps

module fetchFrontEnd
(
	input  logic                clock,
	input  logic                arstN,
	input  logic                fetchEnable,
	input  logic                redirectValid,
	input  fetchPkg::pcAddrT    redirectPc,
	input  logic                memWriteEn,   // preload port
	input  fetchPkg::tileAddrT  memWriteAddr,
	input  fetchPkg::tileDataT  memWriteData,
	output fetchPkg::instrWordT instrWord,
	output fetchPkg::pcAddrT    instrPc,
	output logic                instrValid
);

	import fetchPkg::*;

	pcAddrT   pc;
	fetchOkT  fetchOk;
	tileAddrT memAddr;
	memOpmT   memOpm;
	memOkT    memOk;
	tileDataT memData;

	fetchPcUnit pcUnit
	(
		.clock         (clock),
		.arstN         (arstN),
		.fetchEnable   (fetchEnable),
		.redirectValid (redirectValid),
		.redirectPc    (redirectPc),
		.fetchOk       (fetchOk),
		.pc            (pc)
	);

	icacheTile cacheTile
	(
		.clock     (clock),
		.arstN     (arstN),
		.pc        (pc),
		.fetchOk   (fetchOk),
		.instrWord (instrWord),
		.memAddr   (memAddr),
		.memOpm    (memOpm),
		.memOk     (memOk),
		.memData   (memData)
	);

	tileMemory memory
	(
		.clock        (clock),
		.arstN        (arstN),
		.memAddr      (memAddr),
		.memOpm       (memOpm),
		.memOk        (memOk),
		.memData      (memData),
		.memWriteEn   (memWriteEn),
		.memWriteAddr (memWriteAddr),
		.memWriteData (memWriteData)
	);

	assign instrPc    = pc;
	assign instrValid = fetchEnable && (fetchOk == FETCH_OK_OK); // word consumed this cycle

endmodule

//--- dv/fetchFrontEnd_asserts.sv
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetchFrontEndAsserts
(
	input logic               clock,
	input logic               arstN,
	input fetchPkg::tileAddrT memAddr,
	input fetchPkg::memOpmT   memOpm,
	input fetchPkg::memOkT    memOk,
	input fetchPkg::fetchOkT  fetchOk,
	input logic               tileReady
);

	import fetchPkg::*;

	// request address may not move until the read is answered
	addrStable: assert property (@(posedge clock) disable iff (!arstN)
		(memOpm == MEM_OPM_RD_TILE) |=> (memOpm != MEM_OPM_RD_TILE) || $stable(memAddr))
		else $error("memAddr changed while a tile read was pending");

	okOneCycle: assert property (@(posedge clock) disable iff (!arstN)
		(memOk == MEM_OK_OK) |=> (memOk != MEM_OK_OK))
		else $error("memOk stayed OK for more than one cycle");

	// memory is always idle when a new request rises
	okLatency: assert property (@(posedge clock) disable iff (!arstN)
		$rose(memOpm == MEM_OPM_RD_TILE) |-> ##(`FETCH_MEM_LATENCY) (memOk == MEM_OK_OK))
		else $error("memOk did not follow the request after the memory latency");

	holdWhenEmpty: assert property (@(posedge clock) disable iff (!arstN)
		!tileReady |-> (fetchOk == FETCH_OK_HOLD))
		else $error("fetchOk was not HOLD while the tile was not ready");

endmodule

// memory side is observed through the tile's own ports
bind icacheTile fetchFrontEndAsserts tileProtocolChecks
(
	.clock     (clock),
	.arstN     (arstN),
	.memAddr   (memAddr),
	.memOpm    (memOpm),
	.memOk     (memOk),
	.fetchOk   (fetchOk),
	.tileReady (tileReady)
);

//--- dv/fetchFrontEndTb.sv
`timescale 1ns/1ps

module fetchFrontEndTb;

	import fetchPkg::*;

	logic      clock;
	logic      arstN;
	logic      fetchEnable;
	logic      redirectValid;
	pcAddrT    redirectPc;
	logic      memWriteEn;
	tileAddrT  memWriteAddr;
	tileDataT  memWriteData;
	instrWordT instrWord;
	pcAddrT    instrPc;
	logic      instrValid;

	byte       recKind [$];  // W, R, P or E
	pcAddrT    recAddr [$];  // tile index for W, byte address for R
	tileDataT  recData [$];
	int        recCycles [$];
	pcAddrT    expPc [$];
	instrWordT expWord [$];

	int   eIdx = 0;          // expected words consumed
	int   mismatchCount = 0;
	int   otherCount = 0;
	logic traceLoaded = 1'b0;

	fetchFrontEnd UUT
	(
		.clock         (clock),
		.arstN         (arstN),
		.fetchEnable   (fetchEnable),
		.redirectValid (redirectValid),
		.redirectPc    (redirectPc),
		.memWriteEn    (memWriteEn),
		.memWriteAddr  (memWriteAddr),
		.memWriteData  (memWriteData),
		.instrWord     (instrWord),
		.instrPc       (instrPc),
		.instrValid    (instrValid)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic checkPc(input pcAddrT actual, input pcAddrT expected);
		if (actual !== expected)
		begin
			mismatchCount++;
			$display("mismatch instrPc: got %h, expected %h", actual, expected);
		end
	endtask

	task automatic checkWord(input instrWordT actual, input instrWordT expected);
		if (actual !== expected)
		begin
			mismatchCount++;
			$display("mismatch instrWord: got %h, expected %h", actual, expected);
		end
	endtask

	task automatic loadTrace;
		int        fd;
		int        fields;
		int        cycles;
		string     line;
		pcAddrT    addr;
		tileDataT  data;
		instrWordT word;
		fd = $fopen("dv/fetch_trace.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the trace file dv/fetch_trace.txt");
			otherCount++;
		end
		else
		begin
			while ($fgets(line, fd) > 0)
			begin
				if ((line.len() > 1) && (line[0] != "#"))
				begin
					addr   = '0;
					data   = '0;
					word   = '0;
					cycles = 0;
					case (line[0])
						"W": fields = $sscanf(line, "W %h %h", addr, data) - 2;
						"R": fields = $sscanf(line, "R %h", addr) - 1;
						"P": fields = $sscanf(line, "P %d", cycles) - 1;
						"E": fields = $sscanf(line, "E %h %h", addr, word) - 2;
						default: fields = -1;
					endcase
					if (fields != 0)
					begin
						$display("trace line could not be read: %s", line);
						otherCount++;
					end
					else
					begin
						recKind.push_back(line[0]);
						recAddr.push_back(addr);
						recData.push_back(data);
						recCycles.push_back(cycles);
						if (line[0] == "E")
						begin
							expPc.push_back(addr);
							expWord.push_back(word);
						end
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// returns 1 ns after the first edge with all earlier words seen
	task automatic waitConsumed(input int target);
		@(posedge clock);
		while (eIdx < target)
			@(posedge clock);
		#1;
	endtask

	task automatic writeTile(input tileAddrT addr, input tileDataT data);
		memWriteEn   = 1'b1;
		memWriteAddr = addr;
		memWriteData = data;
		@(posedge clock);
		#1;
		memWriteEn = 1'b0;
	endtask

	task automatic redirectTo(input pcAddrT target);
		redirectValid = 1'b1;
		redirectPc    = target;
		fetchEnable   = 1'b0; // no stray word from the old stream
		@(posedge clock);
		#1;
		redirectValid = 1'b0;
		fetchEnable   = 1'b1;
	endtask

	// single line, so the tile of the last word stays unless pc stepped out of it
	function automatic logic cachedTileHit(input pcAddrT lastPc, input pcAddrT dest);
		pcAddrT stepPc;
		stepPc = lastPc + pcAddrT'(2);
		return (dest[$bits(pcAddrT)-1:4] == lastPc[$bits(pcAddrT)-1:4])
			&& (stepPc[$bits(pcAddrT)-1:4] == lastPc[$bits(pcAddrT)-1:4]);
	endfunction

	// a hit must be valid in the first cycle after the redirect edge
	task automatic checkHitWithoutGap(input pcAddrT dest);
		@(negedge clock);
		if (instrValid !== 1'b1)
		begin
			$display("redirect to %h hit the cached tile but gave no word right away", dest);
			otherCount++;
		end
	endtask

	task automatic pauseFetch(input int cycles);
		fetchEnable = 1'b0;
		repeat (cycles) @(posedge clock);
		#1;
		fetchEnable = 1'b1;
	endtask

	task automatic runTrace;
		int   target;
		logic hitExpected;
		target = 0;
		foreach (recKind[i])
		begin
			if (recKind[i] == "E")
			begin
				target++; // checked by the monitor
			end
			else
			begin
				waitConsumed(target);
				case (recKind[i])
					"W": writeTile(tileAddrT'(recAddr[i]), recData[i]);
					"R":
					begin
						hitExpected = 1'b0;
						if (target > 0)
							hitExpected = cachedTileHit(expPc[target-1], recAddr[i]);
						redirectTo(recAddr[i]);
						if (hitExpected)
							checkHitWithoutGap(recAddr[i]);
					end
					default: pauseFetch(recCycles[i]);
				endcase
			end
		end
		waitConsumed(target);
		fetchEnable = 1'b0;
	endtask

	task automatic reportAndFinish;
		$display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
		if ((mismatchCount == 0) && (otherCount == 0))
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	// every valid cycle must match the next expected record
	always @(negedge clock)
	begin
		if (arstN && instrValid)
		begin
			if (eIdx < expPc.size())
			begin
				checkPc(instrPc, expPc[eIdx]);
				checkWord(instrWord, expWord[eIdx]);
				eIdx++;
			end
			else
			begin
				$display("valid word at pc %h arrived with no expected record left", instrPc);
				otherCount++;
			end
		end
	end

	initial
	begin
		fetchEnable   = 1'b0;
		redirectValid = 1'b0;
		redirectPc    = '0;
		memWriteEn    = 1'b0;
		memWriteAddr  = '0;
		memWriteData  = '0;
		arstN         = 1'b0;
		loadTrace();
		traceLoaded = 1'b1;
		repeat (4) @(posedge clock);
		#1;
		arstN = 1'b1;
		runTrace();
		repeat (12) @(posedge clock); // quiet tail, nothing more may arrive
		if (eIdx != expPc.size())
		begin
			$display("%0d expected words were never delivered", expPc.size() - eIdx);
			otherCount++;
		end
		reportAndFinish();
	end

	// limit scales with the trace length
	initial
	begin
		wait (traceLoaded);
		repeat (20 * recKind.size() + 4) @(posedge clock);
		$display("timeout: only %0d of %0d expected words were delivered", eIdx, expPc.size());
		otherCount++;
		reportAndFinish();
	end

endmodule

//--- project.f
+incdir+hw
hw/fetchPkg.sv
hw/fetchPcUnit.sv
hw/icacheTile.sv
hw/tileMemory.sv
hw/fetchFrontEnd.sv
dv/fetchFrontEnd_asserts.sv
dv/fetchFrontEndTb.sv

//--- Bender.yml
package:
  name: fetch_front_end

sources:
  - include_dirs:
      - hw
    files:
      - hw/fetchPkg.sv
      - hw/fetchPcUnit.sv
      - hw/icacheTile.sv
      - hw/tileMemory.sv
      - hw/fetchFrontEnd.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/fetchFrontEnd_asserts.sv
      - dv/fetchFrontEndTb.sv

//--- dv/fetch_trace.txt
# W: tile index, tile data in hex (word 7 first)   R: redirect byte address
# P: cycles with fetch held off   E: expected instrPc, expected instrWord
# program images, written while fetch is off
W 0010 1a071a061a051a041a031a021a011a00
W 0011 2b072b062b052b042b032b022b012b00
W 0020 3c073c063c053c043c033c023c013c00
# enter tile 0x10 mid-tile, pause once, run across into tile 0x11
R 00104
E 00104 1a02
E 00106 1a03
E 00108 1a04
P 3
E 0010a 1a05
E 0010c 1a06
E 0010e 1a07
E 00110 2b00
E 00112 2b01
E 00114 2b02
E 00116 2b03
# back into the cached tile, hit without a gap
R 00112
E 00112 2b01
E 00114 2b02
P 5
E 00116 2b03
E 00118 2b04
# back to tile 0x10, refill
R 0010a
E 0010a 1a05
E 0010c 1a06
# far tile, run to its end
R 00206
E 00206 3c03
E 00208 3c04
E 0020a 3c05
E 0020c 3c06
E 0020e 3c07
